//--- rtl/fcmpPkg.sv
// Holds the types and constants that every module of the FP compare block imports.
package fcmpPkg;

  // operand format select.
  typedef enum logic [1:0] {
    fmtSng = 2'd0,
    fmtDbl = 2'd1,
    fmtExt = 2'd2
  } fpFmt_e;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fpSingle_t;

  typedef struct packed {
    logic        sign;
    logic [14:0] exp;
    logic [63:0] mant;  // explicit integer bit at 63.
  } fpExtView_t;

  typedef struct packed {
    logic [15:0] pad;
    logic        sign;
    logic [10:0] exp;
    logic [51:0] frac;
  } fpDblView_t;

  typedef struct packed {
    logic [15:0] pad;
    fpSingle_t   hi;
    fpSingle_t   lo;
  } fpPairView_t;

  // one operand word, read per format.
  typedef union packed {
    fpExtView_t  ext;
    fpDblView_t  dbl;
    fpPairView_t pair;
  } fpOperand_u;

  typedef struct packed {
    logic        sign;
    logic [15:0] exp;   // biased, zero extended.
    logic [63:0] mant;  // left aligned, hidden bit explicit.
    logic        isZero;
    logic        isInf;
    logic        isNan;
  } fpUnpacked_t;

  typedef struct packed {
    logic c;
    logic s;
    logic z;
    logic unord;
  } fcmpRes_t;

  typedef struct packed {
    logic notC;
    logic unordHi;
    logic rsvd;
    logic s;
    logic z;
    logic unord;
  } fcmpCmpView_t;

  typedef struct packed {
    logic       has;
    logic [3:0] idx;
    logic       par;
  } fcmpSrchView_t;

  typedef union packed {
    fcmpCmpView_t  cmp;
    fcmpSrchView_t srch;
  } fcmpFlags_u;

  localparam int unsigned SRCH_BITS = 16;
  localparam int unsigned VMASK_W   = 33;
  localparam logic [1:0]  PTYPE_SNG = 2'd1;
  localparam logic [1:0]  PTYPE_DBL = 2'd2;
  localparam int unsigned RES_W     = 68;

endpackage

//--- rtl/fpOperandUnpack.sv
// Splits one operand word into sign, exponent, aligned mantissa and class for the compare.
`timescale 1ns/1ps

module fpOperandUnpack (
  input  fcmpPkg::fpOperand_u  opWord,
  input  fcmpPkg::fpFmt_e      fmt,
  output fcmpPkg::fpUnpacked_t unp
);
  import fcmpPkg::*;

  logic expZero;
  logic expOnes;
  logic fracNz;

  always_comb begin
    unp = '0;
    case (fmt)
      fmtExt: begin
        unp.sign = opWord.ext.sign;
        unp.exp  = {1'b0, opWord.ext.exp};
        unp.mant = opWord.ext.mant;  // integer bit taken as stored.
        expZero  = (opWord.ext.exp == '0);
        expOnes  = &opWord.ext.exp;
        fracNz   = |opWord.ext.mant[62:0];
      end
      fmtDbl: begin
        unp.sign = opWord.dbl.sign;
        unp.exp  = {5'b0, opWord.dbl.exp};
        unp.mant = {1'b1, opWord.dbl.frac, 11'b0};
        expZero  = (opWord.dbl.exp == '0);
        expOnes  = &opWord.dbl.exp;
        fracNz   = |opWord.dbl.frac;
      end
      default: begin
        // single sits in the low word.
        unp.sign = opWord.pair.lo.sign;
        unp.exp  = {8'b0, opWord.pair.lo.exp};
        unp.mant = {1'b1, opWord.pair.lo.frac, 40'b0};
        expZero  = (opWord.pair.lo.exp == '0);
        expOnes  = &opWord.pair.lo.exp;
        fracNz   = |opWord.pair.lo.frac;
      end
    endcase

    // denormals flush to zero.
    if (expZero) begin
      unp.mant = '0;
    end

    unp.isZero = expZero;
    unp.isInf  = expOnes & ~fracNz;
    unp.isNan  = expOnes & fracNz;

    assert ($onehot0({unp.isZero, unp.isInf, unp.isNan}))
      else $error("operand class not exclusive");
  end

endmodule

//--- rtl/fpMagCompare.sv
// Orders two unpacked operands by sign and magnitude and returns the C, S, Z and unordered results.
`timescale 1ns/1ps

module fpMagCompare (
  input  fcmpPkg::fpUnpacked_t opA,
  input  fcmpPkg::fpUnpacked_t opB,
  input  logic                 afm,
  output fcmpPkg::fcmpRes_t    res
);
  import fcmpPkg::*;

  logic [79:0] magA;
  logic [79:0] magB;
  logic [80:0] diff;
  logic        magLt;
  logic        magEq;
  logic        bothZero;
  logic        unord;
  logic        lt;
  logic        eq;

  always_comb begin
    magA = {opA.exp, opA.mant};
    magB = {opB.exp, opB.mant};
    diff = {1'b0, magA} - {1'b0, magB};  // one borrow chain.
    magLt = diff[80];
    magEq = (diff[79:0] == '0);

    bothZero = opA.isZero & opB.isZero;
    unord    = opA.isNan | opB.isNan;

    eq = ~unord & (bothZero | ((opA.sign == opB.sign) & magEq));

    if (unord || bothZero) begin
      lt = 1'b0;
    end else if (opA.sign != opB.sign) begin
      lt = opA.sign;  // negative a is below positive b.
    end else if (opA.sign) begin
      lt = ~magLt & ~magEq;  // order flips for negatives.
    end else begin
      lt = magLt;
    end

    res.c     = lt | unord;
    res.s     = lt & ~afm;
    res.z     = eq & ~afm;
    res.unord = unord;

    assert (!(res.s && res.z))
      else $error("less and equal both set");
    assert (!res.unord || res.c)
      else $error("unordered without carry");
  end

endmodule

//--- rtl/signSearch.sv
// Collects element sign bits of both operands and finds the lowest set one for the search flags.
`timescale 1ns/1ps

module signSearch (
  input  fcmpPkg::fpOperand_u opA,
  input  fcmpPkg::fpOperand_u opB,
  input  logic [1:0]          srchSz,
  output logic                has,
  output logic [3:0]          idx
);
  import fcmpPkg::*;

  localparam int unsigned HALF = SRCH_BITS / 2;

  logic [SRCH_BITS-1:0] srchVec;
  logic [3:0]           elemMask;

  always_comb begin
    srchVec  = '0;
    elemMask = (4'd1 << srchSz) - 4'd1;  // bytes per element minus one.

    // sign of an element lands on its top byte slot.
    for (int k = 0; k < HALF; k++) begin
      if (((k + 1) & int'(elemMask)) == 0) begin
        srchVec[k]        = opA[8*k+7];
        srchVec[k + HALF] = opB[8*k+7];
      end
    end

    has = |srchVec;
    idx = '0;
    for (int i = SRCH_BITS - 1; i >= 0; i--) begin
      if (srchVec[i]) begin
        idx = 4'(i);
      end
    end

    assert (!has || srchVec[idx])
      else $error("search index not on a set bit");
  end

endmodule

//--- rtl/cmpResultPack.sv
// Builds the per-lane masks from the compare results and registers the packed vector word.
`timescale 1ns/1ps

module cmpResultPack (
  input  logic                       clk,
  input  logic                       rst,
  input  fcmpPkg::fcmpRes_t          resMain,
  input  fcmpPkg::fcmpRes_t          resHi,
  input  logic [1:0]                 cmod,
  input  logic                       paired,
  input  logic                       vec,
  output logic [fcmpPkg::RES_W-1:0] resPkd,
  output logic                       resValid
);
  import fcmpPkg::*;

  logic             pred0;
  logic             pred1;
  logic             validNxt;
  logic [1:0]       ptype;
  logic [RES_W-1:0] pkdNxt;

  function automatic logic lanePred(input fcmpRes_t r, input logic [1:0] sel);
    logic p;
    case (sel)
      2'd0:    p = ~r.c;
      2'd1:    p = r.c;
      2'd2:    p = r.z;
      default: p = ~r.z;
    endcase
    return p;
  endfunction

  always_comb begin
    pred0    = lanePred(resMain, cmod);
    pred1    = paired ? lanePred(resHi, cmod) : pred0;  // high lane.
    validNxt = paired | vec;
    ptype    = vec ? PTYPE_DBL : PTYPE_SNG;
    pkdNxt   = '0;
    if (validNxt) begin
      pkdNxt = {ptype, {VMASK_W{pred1}}, {VMASK_W{pred0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resPkd   <= '0;
      resValid <= 1'b0;
    end else begin
      resPkd   <= pkdNxt;
      resValid <= validNxt;
    end
  end

  assert property (@(posedge clk) disable iff (rst) !resValid |-> resPkd == '0)
    else $error("packed result not clear while idle");

endmodule

//--- rtl/fpCompareUnit.sv
// Top of the FP compare block, giving same-cycle flags and a registered vector compare result.
`timescale 1ns/1ps

module fpCompareUnit (
  input  logic                       clk,
  input  logic                       rst,
  input  fcmpPkg::fpOperand_u        a,
  input  fcmpPkg::fpOperand_u        b,
  input  fcmpPkg::fpFmt_e            fmt,
  input  logic                       afm,
  input  logic                       paired,
  input  logic                       vec,
  input  logic                       intSrch,
  input  logic [1:0]                 srchSz,
  input  logic [1:0]                 cmod,
  output fcmpPkg::fcmpFlags_u        flags,
  output logic [fcmpPkg::RES_W-1:0] resPkd,
  output logic                       resValid
);
  import fcmpPkg::*;

  fpOperand_u  aHi;
  fpOperand_u  bHi;
  fpUnpacked_t unpA;
  fpUnpacked_t unpB;
  fpUnpacked_t unpAHi;
  fpUnpacked_t unpBHi;
  fcmpRes_t    resMain;
  fcmpRes_t    resHi;
  logic        srchHas;
  logic [3:0]  srchIdx;

  // high single moved down so the single decoder sees it.
  always_comb begin
    aHi         = '0;
    bHi         = '0;
    aHi.pair.lo = a.pair.hi;
    bHi.pair.lo = b.pair.hi;
  end

  fpOperandUnpack unpackA   (.opWord(a),   .fmt(fmt),    .unp(unpA));
  fpOperandUnpack unpackB   (.opWord(b),   .fmt(fmt),    .unp(unpB));
  fpOperandUnpack unpackAHi (.opWord(aHi), .fmt(fmtSng), .unp(unpAHi));
  fpOperandUnpack unpackBHi (.opWord(bHi), .fmt(fmtSng), .unp(unpBHi));

  fpMagCompare cmpMain (.opA(unpA),   .opB(unpB),   .afm(afm), .res(resMain));
  fpMagCompare cmpHi   (.opA(unpAHi), .opB(unpBHi), .afm(afm), .res(resHi));

  signSearch search (
    .opA   (a),
    .opB   (b),
    .srchSz(srchSz),
    .has   (srchHas),
    .idx   (srchIdx)
  );

  cmpResultPack packer (
    .clk     (clk),
    .rst     (rst),
    .resMain (resMain),
    .resHi   (resHi),
    .cmod    (cmod),
    .paired  (paired),
    .vec     (vec),
    .resPkd  (resPkd),
    .resValid(resValid)
  );

  always_comb begin
    flags = '0;
    if (intSrch) begin
      flags.srch.has = srchHas;
      flags.srch.idx = srchIdx;
      flags.srch.par = ^srchIdx[1:0];
    end else begin
      flags.cmp.notC    = ~resMain.c;
      flags.cmp.unordHi = resMain.unord;
      flags.cmp.s       = resMain.s;
      flags.cmp.z       = resMain.z;
      flags.cmp.unord   = resMain.unord;
    end
  end

endmodule

//--- verif/fpCompareTb.sv
// Testbench for the FP compare unit; runs a directed table, then LCG items checked by a model.
`timescale 1ns/1ps

module fpCompareTb;
  import fcmpPkg::*;

  // mode bits, top down.
  typedef struct packed {
    logic       afm;
    logic       paired;
    logic       vec;
    logic       intSrch;
    logic [1:0] srchSz;
    logic [1:0] cmod;
  } mode_t;

  typedef struct packed {
    logic [79:0]      a;
    logic [79:0]      b;
    logic [1:0]       fmt;
    mode_t            mode;
    logic [5:0]       expFlags;
    logic [RES_W-1:0] expPkd;
  } entry_t;

  typedef struct packed {
    logic        sign;
    logic        zero;
    logic        nan;
    logic [79:0] mag;
  } refOp_t;

  logic             clk;
  logic             rst;
  fpOperand_u       a;
  fpOperand_u       b;
  fpFmt_e           fmt;
  logic             afm;
  logic             paired;
  logic             vec;
  logic             intSrch;
  logic [1:0]       srchSz;
  logic [1:0]       cmod;
  fcmpFlags_u       flags;
  logic [RES_W-1:0] resPkd;
  logic             resValid;

  entry_t      stimTable[$];
  int          errors;
  int          checks;
  logic        timedOut;
  logic [31:0] lcgState;

  fpCompareUnit i_dut (
    .clk     (clk),
    .rst     (rst),
    .a       (a),
    .b       (b),
    .fmt     (fmt),
    .afm     (afm),
    .paired  (paired),
    .vec     (vec),
    .intSrch (intSrch),
    .srchSz  (srchSz),
    .cmod    (cmod),
    .flags   (flags),
    .resPkd  (resPkd),
    .resValid(resValid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic [79:0] randWord(input logic [1:0] f);
    logic [31:0] lo;
    logic [31:0] mid;
    logic [31:0] hi;
    logic [79:0] w;
    lo  = nextRand();
    mid = nextRand();
    hi  = nextRand();
    w   = {hi[15:0], mid, lo};
    if (f == 2'd2) begin
      w[63] = 1'b1;  // normalized extended only.
    end
    return w;
  endfunction

  // magnitude is exponent then fraction, so plain compare gives numeric order.
  function automatic refOp_t refDecode(input logic [79:0] w, input logic [1:0] f);
    refOp_t o;
    o = '0;
    case (f)
      2'd2: begin
        o.sign = w[79];
        o.zero = (w[78:64] == '0);
        o.nan  = (&w[78:64]) & (|w[62:0]);
        o.mag  = {1'b0, w[78:0]};
      end
      2'd1: begin
        o.sign = w[63];
        o.zero = (w[62:52] == '0);
        o.nan  = (&w[62:52]) & (|w[51:0]);
        o.mag  = {17'b0, w[62:0]};
      end
      default: begin
        o.sign = w[31];
        o.zero = (w[30:23] == '0);
        o.nan  = (&w[30:23]) & (|w[22:0]);
        o.mag  = {49'b0, w[30:0]};
      end
    endcase
    if (o.zero) begin
      o.mag = '0;
    end
    return o;
  endfunction

  // returns c, s, z, unord.
  function automatic logic [3:0] refCompare(input logic [79:0] wa, input logic [79:0] wb,
                                            input logic [1:0] f, input logic am);
    refOp_t x;
    refOp_t y;
    logic   unord;
    logic   eq;
    logic   lt;
    x     = refDecode(wa, f);
    y     = refDecode(wb, f);
    unord = x.nan | y.nan;
    eq    = !unord && ((x.zero && y.zero) || (x.sign == y.sign && x.mag == y.mag));
    if (unord || eq) begin
      lt = 1'b0;
    end else if (x.sign != y.sign) begin
      lt = x.sign;
    end else if (x.sign) begin
      lt = x.mag > y.mag;
    end else begin
      lt = x.mag < y.mag;
    end
    return {lt | unord, lt & ~am, eq & ~am, unord};
  endfunction

  function automatic logic [5:0] refSearch(input logic [79:0] wa, input logic [79:0] wb,
                                           input logic [1:0] sz);
    logic [15:0] v;
    logic        has;
    logic [3:0]  idx;
    v   = '0;
    has = 1'b0;
    idx = '0;
    for (int m = 0; m < 8; m++) begin
      if (sz == 2'd0) begin
        v[m]     = wa[8*m+7];
        v[m + 8] = wb[8*m+7];
      end else if (sz == 2'd1 && m < 4) begin
        v[2*m+1] = wa[16*m+15];
        v[2*m+9] = wb[16*m+15];
      end else if (sz == 2'd2 && m < 2) begin
        v[4*m+3]  = wa[32*m+31];
        v[4*m+11] = wb[32*m+31];
      end else if (sz == 2'd3 && m == 0) begin
        v[7]  = wa[63];
        v[15] = wb[63];
      end
    end
    for (int i = 0; i < 16; i++) begin
      if (v[i] && !has) begin
        has = 1'b1;
        idx = 4'(i);
      end
    end
    return {has, idx, idx[1] ^ idx[0]};
  endfunction

  function automatic logic lanePredicate(input logic [3:0] r, input logic [1:0] sel);
    case (sel)
      2'd0:    return ~r[3];
      2'd1:    return r[3];
      2'd2:    return r[1];
      default: return ~r[1];
    endcase
  endfunction

  function automatic logic [RES_W-1:0] expandPkd(input logic valid, input logic vecBit,
                                                 input logic [1:0] lanes);
    logic [1:0] ptype;
    ptype = vecBit ? 2'd2 : 2'd1;
    if (!valid) begin
      return '0;
    end
    return {ptype, {33{lanes[1]}}, {33{lanes[0]}}};
  endfunction

  task automatic addDirected(input logic [79:0] wa, input logic [79:0] wb, input logic [1:0] f,
                             input mode_t m, input logic [5:0] fl, input logic [1:0] lanes);
    entry_t e;
    e.a        = wa;
    e.b        = wb;
    e.fmt      = f;
    e.mode     = m;
    e.expFlags = fl;
    e.expPkd   = expandPkd(m.paired | m.vec, m.vec, lanes);
    stimTable.push_back(e);
  endtask

  task automatic addRandom();
    entry_t      e;
    logic [31:0] r;
    logic [3:0]  rm;
    logic [3:0]  rh;
    logic [1:0]  lanes;
    r          = nextRand();
    e.fmt      = 2'(r[31:16] % 16'd3);
    e.mode     = mode_t'(r[7:0]);
    e.mode.afm = r[7] & r[8];
    e.a        = randWord(e.fmt);
    e.b        = (r[11:9] == 3'd0) ? e.a : randWord(e.fmt);  // some equal pairs.
    rm = refCompare(e.a, e.b, e.fmt, e.mode.afm);
    rh = refCompare({48'b0, e.a[63:32]}, {48'b0, e.b[63:32]}, 2'd0, e.mode.afm);
    if (e.mode.intSrch) begin
      e.expFlags = refSearch(e.a, e.b, e.mode.srchSz);
    end else begin
      e.expFlags = {~rm[3], rm[0], 1'b0, rm[2], rm[1], rm[0]};
    end
    lanes[0] = lanePredicate(rm, e.mode.cmod);
    lanes[1] = e.mode.paired ? lanePredicate(rh, e.mode.cmod) : lanes[0];
    e.expPkd = expandPkd(e.mode.paired | e.mode.vec, e.mode.vec, lanes);
    stimTable.push_back(e);
  endtask

  task automatic buildTable();
    // compare view, formats 0 sng, 1 dbl, 2 ext.
    addDirected(80'h3f800000, 80'h40000000, 2'd0, 8'h00, 6'h04, 2'b00);
    addDirected(80'h40000000, 80'h3f800000, 2'd0, 8'h00, 6'h20, 2'b00);
    addDirected(80'hbf800000, 80'h3f800000, 2'd0, 8'h00, 6'h04, 2'b00);
    addDirected(80'h4000000000000000, 80'h4000000000000000, 2'd1, 8'h00, 6'h22, 2'b00);
    addDirected(80'h3fff_8000000000000000, 80'h4000_8000000000000000, 2'd2, 8'h00, 6'h04, 2'b00);
    addDirected(80'h0, 80'h8000_0000000000000000, 2'd2, 8'h00, 6'h22, 2'b00);
    addDirected(80'h80000000, 80'h0, 2'd0, 8'h00, 6'h22, 2'b00);
    addDirected(80'h7ff0000000000000, 80'h7ff0000000000000, 2'd1, 8'h00, 6'h22, 2'b00);
    addDirected(80'h7fff_8000000000000000, 80'h7fff_8000000000000000, 2'd2, 8'h00, 6'h22, 2'b00);
    addDirected(80'hc000000000000000, 80'hbff0000000000000, 2'd1, 8'h00, 6'h04, 2'b00);
    addDirected(80'hbfff_8000000000000000, 80'hc000_8000000000000000, 2'd2, 8'h00, 6'h20, 2'b00);
    addDirected(80'h7fc00000, 80'h3f800000, 2'd0, 8'h00, 6'h11, 2'b00);
    addDirected(80'h3ff0000000000000, 80'h7ff8000000000000, 2'd1, 8'h00, 6'h11, 2'b00);
    addDirected(80'h7fff_c000000000000000, 80'h7fff_c000000000000000, 2'd2, 8'h00, 6'h11, 2'b00);
    addDirected(80'h3f800000, 80'h40000000, 2'd0, 8'h80, 6'h00, 2'b00);
    addDirected(80'h4000000000000000, 80'h4000000000000000, 2'd1, 8'h80, 6'h20, 2'b00);
    // search view, each element size.
    addDirected(80'h8000, 80'h0, 2'd0, 8'h10, 6'h23, 2'b00);
    addDirected(80'h80, 80'h8000_0000_0000, 2'd0, 8'h14, 6'h3b, 2'b00);
    addDirected(80'h8000_0000_0000_8000, 80'h0, 2'd0, 8'h18, 6'h2e, 2'b00);
    addDirected(80'h8000_0000, 80'h8000_0000_0000_0000, 2'd0, 8'h1c, 6'h3e, 2'b00);
    addDirected(80'h7f7f, 80'h7f7f_7f7f, 2'd0, 8'h10, 6'h00, 2'b00);
    // vector results, lanes given high then low.
    addDirected(80'h3f800000, 80'h40000000, 2'd0, 8'h20, 6'h04, 2'b00);
    addDirected(80'h3f800000, 80'h40000000, 2'd0, 8'h21, 6'h04, 2'b11);
    addDirected(80'h40000000, 80'h40000000, 2'd0, 8'h22, 6'h22, 2'b11);
    addDirected(80'h40000000, 80'h40000000, 2'd0, 8'h23, 6'h22, 2'b00);
    addDirected(80'h40000000_3f800000, 80'h3f800000_40000000, 2'd0, 8'h41, 6'h04, 2'b01);
    addDirected(80'h3f800000_3f800000, 80'h3f800000_40000000, 2'd0, 8'h42, 6'h04, 2'b10);
    addDirected(80'h7fc00000_40000000, 80'h3f800000_3f800000, 2'd0, 8'h60, 6'h20, 2'b01);
    addDirected(80'h40000000_3f800000, 80'h3f800000_3f800000, 2'd0, 8'h22, 6'h22, 2'b11);
    addDirected(80'h4000000000000000, 80'h3ff0000000000000, 2'd1, 8'h21, 6'h20, 2'b00);
    repeat (200) addRandom();
  endtask

  task automatic checkValue(input logic [RES_W-1:0] got, input logic [RES_W-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic waitIdle();
    int n;
    n = 0;
    while (resValid !== 1'b0 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (resValid !== 1'b0) begin
      timedOut = 1'b1;
      $display("timeout: resValid did not clear within 20 cycles after reset");
    end
  endtask

  task automatic driveEntry(input entry_t e);
    @(posedge clk);
    a       <= e.a;
    b       <= e.b;
    fmt     <= fpFmt_e'(e.fmt);
    afm     <= e.mode.afm;
    paired  <= e.mode.paired;
    vec     <= e.mode.vec;
    intSrch <= e.mode.intSrch;
    srchSz  <= e.mode.srchSz;
    cmod    <= e.mode.cmod;
  endtask

  initial begin
    entry_t prev;
    entry_t idle;
    lcgState = 32'h42e31277;
    errors   = 0;
    checks   = 0;
    timedOut = 1'b0;
    idle     = '0;
    prev     = '0;
    rst     <= 1'b1;
    a       <= '0;
    b       <= '0;
    fmt     <= fmtSng;
    afm     <= 1'b0;
    paired  <= 1'b0;
    vec     <= 1'b0;
    intSrch <= 1'b0;
    srchSz  <= '0;
    cmod    <= '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkValue(RES_W'(resValid), RES_W'(1'b0), "resValid after reset");
    checkValue(resPkd, '0, "resPkd after reset");
    waitIdle();
    if (!timedOut) begin
      buildTable();
      for (int i = 0; i <= stimTable.size(); i++) begin
        driveEntry((i < stimTable.size()) ? stimTable[i] : idle);  // idle item flushes the last.
        @(negedge clk);
        if (i < stimTable.size()) begin
          checkValue(RES_W'(flags), RES_W'(stimTable[i].expFlags), $sformatf("flags item %0d", i));
        end
        if (i > 0) begin
          checkValue(resPkd, prev.expPkd, $sformatf("resPkd item %0d", i - 1));
          checkValue(RES_W'(resValid), RES_W'(prev.mode.paired | prev.mode.vec),
                     $sformatf("resValid item %0d", i - 1));
        end
        if (i < stimTable.size()) begin
          prev = stimTable[i];
        end
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !timedOut) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
rtl/fcmpPkg.sv
rtl/fpOperandUnpack.sv
rtl/fpMagCompare.sv
rtl/signSearch.sv
rtl/cmpResultPack.sv
rtl/fpCompareUnit.sv
verif/fpCompareTb.sv

//--- run.sh
#!/bin/sh
# Build the FP compare testbench with Verilator, run it, and scan the log for failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=fpCompareTb

if ! verilator --binary --assert --timing --top-module "$TOP" -Mdir "$OBJ" -f src.f; then
  echo "Verilator build failed"
  exit 1
fi

if [ ! -x "./$OBJ/V$TOP" ]; then
  echo "simulation binary not found"
  exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi

exit 0
